/* Makefile */
# Verilator flow for the memory-access stage.
# Override any variable on the command line, e.g. make sim TOP=tb_mem_stage

VERILATOR ?= verilator
TOP       ?= tb_mem_stage
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The simulation binary exits with a non-zero status when the testbench stops on $fatal.
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* common/mem_stage_pkg.sv */
package mem_stage_pkg;

    typedef logic [31:0] word_t;    // Data or address word.
    typedef logic [7:0]  mem_op_t;  // One-hot memory operation.
    typedef logic [4:0]  reg_idx_t; // Destination register index.
    typedef logic [5:0]  ecode_t;   // Exception code.
    typedef logic [3:0]  strb_t;    // Byte write strobe, one bit per lane.
    typedef logic [1:0]  size_t;    // Access size as seen on the data bus.

    // Bit positions inside mem_op.
    localparam int OP_LB  = 0;
    localparam int OP_LH  = 1;
    localparam int OP_LW  = 2;
    localparam int OP_LBU = 3;
    localparam int OP_LHU = 4;
    localparam int OP_SB  = 5;
    localparam int OP_SH  = 6;
    localparam int OP_SW  = 7;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    localparam ecode_t ECODE_NONE = 6'h00;
    localparam ecode_t ECODE_ALE  = 6'h09; // Address alignment exception.

    // Bus FSM states.
    // BUS_IDLE waits for an access and drives req.
    // BUS_WAIT_DATA has finished the address phase and waits for data_ok.
    // BUS_HELD keeps the returned data while writeback stalls.
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT_DATA,
        BUS_HELD
    } bus_state_t;

endpackage

/* mem_stage/load_result_align.sv */
module load_result_align (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  logic                    out_ready,
    input  mem_stage_pkg::mem_op_t  mem_op,
    input  mem_stage_pkg::word_t    alu_result,
    input  mem_stage_pkg::word_t    load_word,
    input  logic                    align_fault,
    input  mem_stage_pkg::word_t    pc,
    input  mem_stage_pkg::reg_idx_t dest,
    input  logic                    gr_we,
    output logic                    out_valid,
    output mem_stage_pkg::word_t    pc_out,
    output mem_stage_pkg::word_t    result_out,
    output mem_stage_pkg::reg_idx_t dest_out,
    output logic                    gr_we_out,
    output logic                    has_exception_out,
    output mem_stage_pkg::ecode_t   ecode_out,
    output mem_stage_pkg::word_t    badv_out
);

    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    mem_stage_pkg::word_t stage_result;

    always_comb begin
        case (alu_result[1:0])
            2'd0: byte_lane = load_word[7:0];
            2'd1: byte_lane = load_word[15:8];
            2'd2: byte_lane = load_word[23:16];
            default: byte_lane = load_word[31:24];
        endcase
    end

    assign half_lane = alu_result[1] ? load_word[31:16] : load_word[15:0];

    always_comb begin
        stage_result = alu_result; // Stores and ALU instructions pass the address/result through.
        if (!align_fault) begin
            if (mem_op[mem_stage_pkg::OP_LB]) begin
                stage_result = {{24{byte_lane[7]}}, byte_lane};
            end else if (mem_op[mem_stage_pkg::OP_LBU]) begin
                stage_result = {24'd0, byte_lane};
            end else if (mem_op[mem_stage_pkg::OP_LH]) begin
                stage_result = {{16{half_lane[15]}}, half_lane};
            end else if (mem_op[mem_stage_pkg::OP_LHU]) begin
                stage_result = {16'd0, half_lane};
            end else if (mem_op[mem_stage_pkg::OP_LW]) begin
                stage_result = load_word;
            end
        end
    end

    // A held result stays put until writeback takes it.
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_ready) begin
            out_valid <= advance;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gr_we_out         <= 1'b0;
            has_exception_out <= 1'b0;
        end else if (advance) begin
            gr_we_out         <= gr_we & ~align_fault; // No writeback on a fault.
            has_exception_out <= align_fault;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            pc_out     <= pc;
            result_out <= stage_result;
            dest_out   <= dest;
            ecode_out  <= align_fault ? mem_stage_pkg::ECODE_ALE : mem_stage_pkg::ECODE_NONE;
            badv_out   <= align_fault ? alu_result : '0;
        end
    end

endmodule

/* mem_stage/mem_access_decode.sv */
module mem_access_decode (
    input  mem_stage_pkg::mem_op_t mem_op,
    input  mem_stage_pkg::word_t   alu_result,
    input  mem_stage_pkg::word_t   rkd_value,
    output logic                   mem_access,
    output logic                   is_store,
    output mem_stage_pkg::size_t   size,
    output mem_stage_pkg::strb_t   wstrb,
    output mem_stage_pkg::word_t   wdata,
    output logic                   align_fault
);

    logic                 is_load;
    logic                 is_half;
    logic                 is_word;
    logic [1:0]           offset;
    mem_stage_pkg::strb_t lane_strb;

    assign offset = alu_result[1:0];

    assign is_load = mem_op[mem_stage_pkg::OP_LB]
                   | mem_op[mem_stage_pkg::OP_LH]
                   | mem_op[mem_stage_pkg::OP_LW]
                   | mem_op[mem_stage_pkg::OP_LBU]
                   | mem_op[mem_stage_pkg::OP_LHU];

    assign is_store = mem_op[mem_stage_pkg::OP_SB]
                    | mem_op[mem_stage_pkg::OP_SH]
                    | mem_op[mem_stage_pkg::OP_SW];

    assign is_half = mem_op[mem_stage_pkg::OP_LH]
                   | mem_op[mem_stage_pkg::OP_LHU]
                   | mem_op[mem_stage_pkg::OP_SH];

    assign is_word = mem_op[mem_stage_pkg::OP_LW] | mem_op[mem_stage_pkg::OP_SW];

    assign mem_access = is_load | is_store;

    // Halfwords need an even address, words a multiple of four.
    assign align_fault = (is_half & offset[0]) | (is_word & (|offset));

    always_comb begin
        if (is_word) begin
            size = mem_stage_pkg::SIZE_WORD;
        end else if (is_half) begin
            size = mem_stage_pkg::SIZE_HALF;
        end else begin
            size = mem_stage_pkg::SIZE_BYTE;
        end
    end

    always_comb begin
        lane_strb = '0;
        if (mem_op[mem_stage_pkg::OP_SB]) begin
            lane_strb = 4'b0001 << offset;
        end else if (mem_op[mem_stage_pkg::OP_SH]) begin
            lane_strb = 4'b0011 << offset;
        end else if (mem_op[mem_stage_pkg::OP_SW]) begin
            lane_strb = 4'b1111;
        end
    end

    assign wstrb = align_fault ? '0 : lane_strb; // A faulting store writes nothing.

    // The value is copied to every lane so the strobe alone picks the target bytes.
    always_comb begin
        wdata = '0;
        if (mem_op[mem_stage_pkg::OP_SB]) begin
            wdata = {4{rkd_value[7:0]}};
        end else if (mem_op[mem_stage_pkg::OP_SH]) begin
            wdata = {2{rkd_value[15:0]}};
        end else if (mem_op[mem_stage_pkg::OP_SW]) begin
            wdata = rkd_value;
        end
    end

endmodule

/* mem_stage/mem_bus_request.sv */
module mem_bus_request (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  logic                 mem_access,
    input  logic                 align_fault,
    input  logic                 out_ready,
    input  logic                 addr_ok,
    input  logic                 data_ok,
    input  mem_stage_pkg::word_t rdata,
    output logic                 req,
    output logic                 in_ready,
    output logic                 advance,
    output mem_stage_pkg::word_t load_word
);

    mem_stage_pkg::bus_state_t state;
    mem_stage_pkg::bus_state_t state_next;
    mem_stage_pkg::word_t      held_word;
    logic                      need_bus;
    logic                      data_done;
    logic                      ready_go;

    // Misaligned accesses complete without touching the bus.
    assign need_bus = in_valid & mem_access & ~align_fault;

    assign req = need_bus & (state == mem_stage_pkg::BUS_IDLE);

    assign data_done = (state == mem_stage_pkg::BUS_WAIT_DATA) & data_ok;

    // The instruction is finished once its data phase has come back.
    assign ready_go = ~need_bus
                    | data_done
                    | (state == mem_stage_pkg::BUS_HELD);

    assign in_ready = ~in_valid | (ready_go & out_ready);
    assign advance  = in_valid & ready_go & out_ready;

    always_comb begin
        state_next = state;
        case (state)
            mem_stage_pkg::BUS_IDLE: begin
                if (req && addr_ok) begin
                    state_next = mem_stage_pkg::BUS_WAIT_DATA;
                end
            end
            mem_stage_pkg::BUS_WAIT_DATA: begin
                if (data_ok) begin
                    state_next = out_ready ? mem_stage_pkg::BUS_IDLE : mem_stage_pkg::BUS_HELD;
                end
            end
            mem_stage_pkg::BUS_HELD: begin
                if (out_ready) begin
                    state_next = mem_stage_pkg::BUS_IDLE;
                end
            end
            default: begin
                state_next = mem_stage_pkg::BUS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_stage_pkg::BUS_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Read data is only valid in the data_ok cycle, so keep it during a stall.
    always_ff @(posedge clk) begin
        if (data_done && !out_ready) begin
            held_word <= rdata;
        end
    end

    assign load_word = (state == mem_stage_pkg::BUS_HELD) ? held_word : rdata;

endmodule

/* mem_stage/mem_stage_top.sv */
module mem_stage_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    in_valid,
    output logic                    in_ready,
    input  mem_stage_pkg::word_t    pc,
    input  mem_stage_pkg::word_t    alu_result,
    input  mem_stage_pkg::mem_op_t  mem_op,
    input  mem_stage_pkg::word_t    rkd_value,
    input  mem_stage_pkg::reg_idx_t dest,
    input  logic                    gr_we,

    output logic                    out_valid,
    input  logic                    out_ready,
    output mem_stage_pkg::word_t    pc_out,
    output mem_stage_pkg::word_t    result_out,
    output mem_stage_pkg::reg_idx_t dest_out,
    output logic                    gr_we_out,
    output logic                    has_exception_out,
    output mem_stage_pkg::ecode_t   ecode_out,
    output mem_stage_pkg::word_t    badv_out,

    output logic                    req,
    output logic                    wr,
    output mem_stage_pkg::size_t    size,
    output mem_stage_pkg::word_t    addr,
    output mem_stage_pkg::strb_t    wstrb,
    output mem_stage_pkg::word_t    wdata,
    input  logic                    addr_ok,
    input  logic                    data_ok,
    input  mem_stage_pkg::word_t    rdata
);

    logic                 mem_access;
    logic                 is_store;
    logic                 align_fault;
    logic                 advance;
    mem_stage_pkg::word_t load_word;

    assign wr   = is_store;
    assign addr = alu_result; // The bus address is the effective address from execute.

    mem_access_decode u_decode (
        .mem_op      (mem_op),
        .alu_result  (alu_result),
        .rkd_value   (rkd_value),
        .mem_access  (mem_access),
        .is_store    (is_store),
        .size        (size),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .align_fault (align_fault)
    );

    mem_bus_request u_bus_request (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .mem_access  (mem_access),
        .align_fault (align_fault),
        .out_ready   (out_ready),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .req         (req),
        .in_ready    (in_ready),
        .advance     (advance),
        .load_word   (load_word)
    );

    load_result_align u_result (
        .clk               (clk),
        .rst               (rst),
        .advance           (advance),
        .out_ready         (out_ready),
        .mem_op            (mem_op),
        .alu_result        (alu_result),
        .load_word         (load_word),
        .align_fault       (align_fault),
        .pc                (pc),
        .dest              (dest),
        .gr_we             (gr_we),
        .out_valid         (out_valid),
        .pc_out            (pc_out),
        .result_out        (result_out),
        .dest_out          (dest_out),
        .gr_we_out         (gr_we_out),
        .has_exception_out (has_exception_out),
        .ecode_out         (ecode_out),
        .badv_out          (badv_out)
    );

endmodule

/* sim.f */
common/mem_stage_pkg.sv
mem_stage/mem_access_decode.sv
mem_stage/mem_bus_request.sv
mem_stage/load_result_align.sv
mem_stage/mem_stage_top.sv
testbench/tb_sram_model.sv
testbench/tb_mem_stage.sv

/* testbench/tb_mem_stage.sv */
module tb_mem_stage;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int     NUM_INSTR      = 300;
    localparam int     NUM_STORES     = 100;
    localparam int     TIMEOUT_CYCLES = 40 * NUM_INSTR;
    localparam integer SEED           = 32'h7d61_e990;

    logic                      clk;
    logic                      rst;
    logic                      in_valid;
    logic                      in_ready;
    mem_stage_pkg::word_t      pc;
    mem_stage_pkg::word_t      alu_result;
    mem_stage_pkg::mem_op_t    mem_op;
    mem_stage_pkg::word_t      rkd_value;
    mem_stage_pkg::reg_idx_t   dest;
    logic                      gr_we;
    logic                      out_valid;
    logic                      out_ready;
    mem_stage_pkg::word_t      pc_out;
    mem_stage_pkg::word_t      result_out;
    mem_stage_pkg::reg_idx_t   dest_out;
    logic                      gr_we_out;
    logic                      has_exception_out;
    mem_stage_pkg::ecode_t     ecode_out;
    mem_stage_pkg::word_t      badv_out;
    logic                      req;
    logic                      wr;
    mem_stage_pkg::size_t      size;
    mem_stage_pkg::word_t      addr;
    mem_stage_pkg::strb_t      wstrb;
    mem_stage_pkg::word_t      wdata;
    logic                      addr_ok;
    logic                      data_ok;
    mem_stage_pkg::word_t      rdata;

    integer                    seed = SEED;
    logic [7:0]                shadow [0:255];  // Expected memory contents, byte addressed.
    logic [71:0]               exp_q [$];       // {gr_we, has_exception, ecode, badv, result}
    mem_stage_pkg::word_t      pc_q [$];
    mem_stage_pkg::reg_idx_t   dest_q [$];
    logic                      cur_needs_bus;
    int                        expected_phases;
    int                        cycle_count = 0;
    mem_stage_pkg::bus_state_t bus_state;

    assign bus_state = UUT.u_bus_request.state;

    mem_stage_top UUT (.*);

    tb_sram_model #(.SEED(SEED)) u_sram (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic mem_stage_pkg::word_t align_down(input mem_stage_pkg::mem_op_t op,
                                                        input mem_stage_pkg::word_t a);
        mem_stage_pkg::word_t r;
        r = a;
        if (op[mem_stage_pkg::OP_LW] || op[mem_stage_pkg::OP_SW]) begin
            r[1:0] = 2'd0;
        end else if (op[mem_stage_pkg::OP_LH] || op[mem_stage_pkg::OP_LHU]
                     || op[mem_stage_pkg::OP_SH]) begin
            r[0] = 1'b0;
        end
        return r;
    endfunction

    function automatic logic misaligned(input mem_stage_pkg::mem_op_t op,
                                        input mem_stage_pkg::word_t a);
        return align_down(op, a) != a;
    endfunction

    // Bus size code: 0 for bytes, 1 for halfwords, 2 for words.
    function automatic mem_stage_pkg::size_t expected_size(input mem_stage_pkg::mem_op_t op);
        if (op[mem_stage_pkg::OP_LW] || op[mem_stage_pkg::OP_SW]) begin
            return 2'd2;
        end
        if (op[mem_stage_pkg::OP_LH] || op[mem_stage_pkg::OP_LHU]
            || op[mem_stage_pkg::OP_SH]) begin
            return 2'd1;
        end
        return 2'd0;
    endfunction

    function automatic logic [71:0] expected_result(input mem_stage_pkg::mem_op_t op,
                                                    input mem_stage_pkg::word_t a,
                                                    input logic we);
        int                   b;
        int                   w;
        mem_stage_pkg::word_t res;
        b   = int'(a[7:0]);
        w   = b & ~3;
        res = a; // Stores and ALU results come back unchanged.
        if (misaligned(op, a)) begin
            return {1'b0, 1'b1, mem_stage_pkg::ECODE_ALE, a, res};
        end
        if (op[mem_stage_pkg::OP_LB])  res = {{24{shadow[b][7]}}, shadow[b]};
        if (op[mem_stage_pkg::OP_LBU]) res = {24'd0, shadow[b]};
        if (op[mem_stage_pkg::OP_LH])  res = {{16{shadow[b+1][7]}}, shadow[b+1], shadow[b]};
        if (op[mem_stage_pkg::OP_LHU]) res = {16'd0, shadow[b+1], shadow[b]};
        if (op[mem_stage_pkg::OP_LW])  res = {shadow[w+3], shadow[w+2], shadow[w+1], shadow[w]};
        return {we, 1'b0, mem_stage_pkg::ECODE_NONE, 32'd0, res};
    endfunction

    task automatic update_shadow(input mem_stage_pkg::mem_op_t op,
                                 input mem_stage_pkg::word_t a,
                                 input mem_stage_pkg::word_t d);
        int b;
        b = int'(a[7:0]);
        if (op[mem_stage_pkg::OP_SB]) shadow[b] = d[7:0];
        if (op[mem_stage_pkg::OP_SH]) begin
            shadow[b]   = d[7:0];
            shadow[b+1] = d[15:8];
        end
        if (op[mem_stage_pkg::OP_SW]) begin
            for (int k = 0; k < 4; k++) shadow[b+k] = d[8*k +: 8];
        end
    endtask

    task automatic check_value(input string field, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, field, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // Holds the instruction until the stage takes it and records what should come out.
    task automatic run_instruction(input mem_stage_pkg::mem_op_t op, input mem_stage_pkg::word_t a,
                                   input mem_stage_pkg::word_t d, input int index);
        logic accepted;
        logic fault;
        fault         = misaligned(op, a);
        in_valid      = 1'b1;
        pc            = 32'h1c00_0000 + 32'(index * 4);
        alu_result    = a;
        mem_op        = op;
        rkd_value     = d;
        dest          = 5'(rand_below(32));
        gr_we         = rand_below(8) != 0;
        cur_needs_bus = (op != '0) && !fault;
        accepted      = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (in_ready) begin
                accepted = 1'b1;
                exp_q.push_back(expected_result(op, a, gr_we));
                pc_q.push_back(pc);
                dest_q.push_back(dest);
                if (cur_needs_bus) expected_phases++;
                if (!fault) update_shadow(op, a, d);
            end
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        mem_stage_pkg::mem_op_t op;
        mem_stage_pkg::word_t   a;
        int                     kind;
        rst             = 1'b1;
        in_valid        = 1'b0;
        pc              = '0;
        alu_result      = '0;
        mem_op          = '0;
        rkd_value       = '0;
        dest            = '0;
        gr_we           = 1'b0;
        cur_needs_bus   = 1'b0;
        expected_phases = 0;
        for (int i = 0; i < 256; i++) shadow[i] = 8'(i * 37 + 11);
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        check_value("req after reset", 32'(req), 32'd0);
        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_INSTR; i++) begin
            kind = (i < NUM_STORES) ? 5 + rand_below(3) : rand_below(10);
            if (kind < 8) begin
                op = mem_stage_pkg::mem_op_t'(8'd1 << kind);
                a  = 32'h0000_8000 | 32'(rand_below(256));
                // About one access in five after the store phase is left misaligned.
                if (i < NUM_STORES || rand_below(5) != 0) a = align_down(op, a);
            end else begin
                op = '0;
                a  = $random(seed);
            end
            run_instruction(op, a, $random(seed), i);
            if (rand_below(4) == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #2;
            end
        end
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        check_value("address phase count", 32'(u_sram.addr_phase_count), 32'(expected_phases));
        $display("Result: PASSED");
        $finish;
    end

    // Writeback back-pressure, about one stalled cycle in four.
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            out_ready = rand_below(4) != 0;
        end
    end

    always @(negedge clk) begin
        logic [71:0]             exp_f;
        mem_stage_pkg::word_t    exp_pc;
        mem_stage_pkg::reg_idx_t exp_dest;
        if (rst) begin
            check_value("out_valid during reset", 32'(out_valid), 32'd0);
            check_value("req during reset", 32'(req), 32'd0);
        end else begin
            if (in_valid && !cur_needs_bus) begin
                check_value("req without a bus access", 32'(req), 32'd0);
            end
            if (req) begin
                check_value("size", 32'(size), 32'(expected_size(mem_op)));
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out at %0t ns with no instruction outstanding.",
                             $time);
                    $display("Result: FAILED");
                    $fatal(1, "Extra result from the stage.");
                end else begin
                    exp_f    = exp_q.pop_front();
                    exp_pc   = pc_q.pop_front();
                    exp_dest = dest_q.pop_front();
                    check_value("pc_out", pc_out, exp_pc);
                    check_value("result_out", result_out, exp_f[31:0]);
                    check_value("dest_out", 32'(dest_out), 32'(exp_dest));
                    check_value("gr_we_out", 32'(gr_we_out), 32'(exp_f[71]));
                    check_value("has_exception_out", 32'(has_exception_out), 32'(exp_f[70]));
                    check_value("ecode_out", 32'(ecode_out), 32'(exp_f[69:64]));
                    check_value("badv_out", badv_out, exp_f[63:32]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d results outstanding, bus FSM in %s.",
                     cycle_count, exp_q.size(), bus_state.name());
            $display("Result: FAILED");
            $fatal(1, "The run did not finish in time.");
        end
    end

endmodule

/* testbench/tb_sram_model.sv */
module tb_sram_model #(
    parameter integer SEED = 0
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  logic                 wr,
    input  mem_stage_pkg::word_t addr,
    input  mem_stage_pkg::strb_t wstrb,
    input  mem_stage_pkg::word_t wdata,
    output logic                 addr_ok,
    output logic                 data_ok,
    output mem_stage_pkg::word_t rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    integer               seed = SEED;
    mem_stage_pkg::word_t mem [0:63];     // 256 bytes, indexed by addr[7:2].
    mem_stage_pkg::word_t read_word;
    logic                 busy;           // Address phase done, data phase pending.
    int                   addr_wait;      // Cycles left before addr_ok may rise.
    int                   data_wait;
    int                   addr_phase_count;

    // With addr_wait at zero the request is taken in the cycle it appears.
    assign addr_ok = req & ~busy & (addr_wait == 0);

    always @(posedge clk) begin
        int delay;
        data_ok <= 1'b0;
        rdata   <= $random(seed); // Garbage outside the data_ok cycle.
        if (rst) begin
            for (int w = 0; w < 64; w++) begin
                for (int k = 0; k < 4; k++) begin
                    mem[w][8*k +: 8] <= 8'((4 * w + k) * 37 + 11);
                end
            end
            busy             <= 1'b0;
            addr_wait        <= int'($unsigned($random(seed)) % 3);
            data_wait        <= 0;
            addr_phase_count <= 0;
        end else if (busy) begin
            if (data_wait == 0) begin
                busy    <= 1'b0;
                data_ok <= 1'b1;
                rdata   <= read_word;
            end else begin
                data_wait <= data_wait - 1;
            end
        end else if (req && addr_ok) begin
            addr_phase_count <= addr_phase_count + 1;
            addr_wait        <= int'($unsigned($random(seed)) % 3);
            read_word        <= mem[addr[7:2]];
            if (wr) begin
                for (int k = 0; k < 4; k++) begin
                    if (wstrb[k]) mem[addr[7:2]][8*k +: 8] <= wdata[8*k +: 8];
                end
            end
            delay = 1 + int'($unsigned($random(seed)) % 3);
            if (delay == 1) begin
                data_ok <= 1'b1;
                rdata   <= mem[addr[7:2]];
            end else begin
                busy      <= 1'b1;
                data_wait <= delay - 2;
            end
        end else if (req && addr_wait != 0) begin
            addr_wait <= addr_wait - 1;
        end
    end

endmodule
